// File: glay_mem_pkg.sv
// Shared widths, depths, read latency and vector types for the vertex property store
package glay_mem_pkg;

	// --------------------------------------------------
	// Property word and byte enables
	// --------------------------------------------------
	localparam int vs_data_w = 32;
	localparam int vs_byte_w = 8;
	localparam int vs_strb_w = vs_data_w / vs_byte_w;

	// --------------------------------------------------
	// Address space and block geometry
	// --------------------------------------------------
	// 4096 vertices, one word each
	localparam int vs_addr_w      = 12;
	// Words per leaf block, so two split levels
	localparam int vs_block_depth = 1024;
	// Cycles from RAM sample to valid read word
	localparam int vs_read_latency = 2;

	// --------------------------------------------------
	// Response buffering and read credits
	// --------------------------------------------------
	localparam int vs_fifo_depth = 4;
	// Counter must reach vs_fifo_depth itself
	localparam int vs_credit_w   = $clog2(vs_fifo_depth + 1);
	localparam int vs_fifo_ptr_w = (vs_fifo_depth > 1) ? $clog2(vs_fifo_depth) : 1;

	// Vector types
	typedef logic [vs_data_w-1:0]     vs_data_t;
	typedef logic [vs_addr_w-1:0]     vs_addr_t;
	typedef logic [vs_strb_w-1:0]     vs_strb_t;
	typedef logic [vs_credit_w-1:0]   vs_credit_t;
	// FIFO slot index
	typedef logic [vs_fifo_ptr_w-1:0] vs_fifo_ptr_t;

endpackage : glay_mem_pkg

// File: vertex_ram_leaf.sv
// One block-sized property RAM with byte write enables, used as the leaf of the split store

`timescale 1ns/1ps

module vertex_ram_leaf #(
	parameter int ADDR_W = $clog2(glay_mem_pkg::vs_block_depth)
) (
	input  logic                   ap_clk,
	input  logic                   ram_en,
	input  glay_mem_pkg::vs_strb_t ram_we,
	input  logic [ADDR_W-1:0]      ram_addr,
	input  glay_mem_pkg::vs_data_t ram_din,
	output glay_mem_pkg::vs_data_t ram_dout
);

	localparam int depth = 2**ADDR_W;
	localparam int lat   = glay_mem_pkg::vs_read_latency;
	localparam int bw    = glay_mem_pkg::vs_byte_w;

	// Storage array, inferred as block RAM
	glay_mem_pkg::vs_data_t mem [depth];

	// Read pipeline, stage 0 is the array output register
	glay_mem_pkg::vs_data_t rd_pipe [lat];

	// --------------------------------------------------
	// Byte-masked write port
	// --------------------------------------------------
	always_ff @(posedge ap_clk) begin
		if (ram_en) begin
			for (int b = 0; b < glay_mem_pkg::vs_strb_w; b++) begin
				if (ram_we[b]) begin
					mem[ram_addr][b*bw +: bw] <= ram_din[b*bw +: bw];
				end
			end
		end
	end

	// --------------------------------------------------
	// Read path
	// --------------------------------------------------
	// Old contents on a write cycle, nobody consumes it
	always_ff @(posedge ap_clk) begin
		if (ram_en) begin
			rd_pipe[0] <= mem[ram_addr];
		end
		// Remaining stages shift every cycle
		for (int i = 1; i < lat; i++) begin
			rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	// Last stage drives the port
	assign ram_dout = rd_pipe[lat-1];

endmodule : vertex_ram_leaf

// File: vertex_ram_split.sv
// Recursive address splitter that builds the vertex store from block-sized leaf RAMs

`timescale 1ns/1ps

module vertex_ram_split #(
	parameter int ADDR_W = glay_mem_pkg::vs_addr_w
) (
	input  logic                   ap_clk,
	input  logic                   rst_n,
	input  logic                   ram_en,
	input  glay_mem_pkg::vs_strb_t ram_we,
	input  logic [ADDR_W-1:0]      ram_addr,
	input  glay_mem_pkg::vs_data_t ram_din,
	output glay_mem_pkg::vs_data_t ram_dout
);

	localparam int lat = glay_mem_pkg::vs_read_latency;

	generate
		if ((2**ADDR_W) > glay_mem_pkg::vs_block_depth) begin : g_split

			// --------------------------------------------------
			// Bank routing by the top address bit
			// --------------------------------------------------
			logic                   top_bit;
			logic                   en_lo;
			logic                   en_hi;
			glay_mem_pkg::vs_strb_t we_lo;
			glay_mem_pkg::vs_strb_t we_hi;
			glay_mem_pkg::vs_data_t dout_lo;
			glay_mem_pkg::vs_data_t dout_hi;

			// Bank select history, one bit per read stage
			logic [lat-1:0]         sel_q;

			assign top_bit = ram_addr[ADDR_W-1];

			// Unselected half sees no enable and no byte writes
			assign en_hi = ram_en & top_bit;
			assign en_lo = ram_en & ~top_bit;
			assign we_hi = top_bit ? ram_we : '0;
			assign we_lo = top_bit ? '0 : ram_we;

			// Select follows the read word through the leaf pipeline
			always_ff @(posedge ap_clk or negedge rst_n) begin
				if (!rst_n) begin
					sel_q <= '0;
				end else begin
					sel_q[0] <= top_bit;
					for (int i = 1; i < lat; i++) begin
						sel_q[i] <= sel_q[i-1];
					end
				end
			end

			// Lower half of the address space
			vertex_ram_split #(
				.ADDR_W(ADDR_W-1)
			) inst_ram_lo (
				.ap_clk  (ap_clk               ),
				.rst_n   (rst_n                ),
				.ram_en  (en_lo                ),
				.ram_we  (we_lo                ),
				.ram_addr(ram_addr[ADDR_W-2:0] ),
				.ram_din (ram_din              ),
				.ram_dout(dout_lo              )
			);

			// Upper half of the address space
			vertex_ram_split #(
				.ADDR_W(ADDR_W-1)
			) inst_ram_hi (
				.ap_clk  (ap_clk               ),
				.rst_n   (rst_n                ),
				.ram_en  (en_hi                ),
				.ram_we  (we_hi                ),
				.ram_addr(ram_addr[ADDR_W-2:0] ),
				.ram_din (ram_din              ),
				.ram_dout(dout_hi              )
			);

			// Delayed select, so back-to-back reads to both banks stay apart
			assign ram_dout = sel_q[lat-1] ? dout_hi : dout_lo;

		end else begin : g_leaf

			// Fits one block, recursion ends here
			vertex_ram_leaf #(
				.ADDR_W(ADDR_W)
			) inst_ram_leaf (
				.ap_clk  (ap_clk  ),
				.ram_en  (ram_en  ),
				.ram_we  (ram_we  ),
				.ram_addr(ram_addr),
				.ram_din (ram_din ),
				.ram_dout(ram_dout)
			);

		end
	endgenerate

endmodule : vertex_ram_split

// File: vertex_req_stage.sv
// Request stage of the vertex store: registers requests onto the RAM port and tracks read credits

`timescale 1ns/1ps

module vertex_req_stage (
	input  logic                   ap_clk,
	input  logic                   rst_n,
	// Request stream
	input  logic                   req_valid,
	output logic                   req_ready,
	input  logic                   req_write,
	input  glay_mem_pkg::vs_strb_t req_strb,
	input  glay_mem_pkg::vs_addr_t req_addr,
	input  glay_mem_pkg::vs_data_t req_data,
	// RAM port
	output logic                   ram_en,
	output glay_mem_pkg::vs_strb_t ram_we,
	output glay_mem_pkg::vs_addr_t ram_addr,
	output glay_mem_pkg::vs_data_t ram_din,
	// Read tracking toward the response FIFO
	output logic                   rd_return,
	input  logic                   rsp_pop
);

	localparam int lat = glay_mem_pkg::vs_read_latency;

	logic                     accept;
	logic                     rd_accept;
	logic                     rd_issue;
	logic [lat-1:0]           rd_sr;
	glay_mem_pkg::vs_credit_t credits;

	// Ready from credits only, never from req_valid
	assign req_ready = (credits != '0);
	assign accept    = req_valid & req_ready;
	assign rd_accept = accept & ~req_write;

	// --------------------------------------------------
	// RAM port control
	// --------------------------------------------------
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			ram_en   <= 1'b0;
			ram_we   <= '0;
			rd_issue <= 1'b0;
		end else begin
			ram_en   <= accept;
			// Strobe becomes per-byte enables, reads write nothing
			ram_we   <= (accept && req_write) ? req_strb : '0;
			rd_issue <= rd_accept;
		end
	end

	// Address and write data, loaded only on a transfer
	always_ff @(posedge ap_clk) begin
		if (accept) begin
			ram_addr <= req_addr;
			ram_din  <= req_data;
		end
	end

	// --------------------------------------------------
	// Read flag delay, lines up with ram_dout
	// --------------------------------------------------
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			rd_sr <= '0;
		end else begin
			rd_sr[0] <= rd_issue;
			for (int i = 1; i < lat; i++) begin
				rd_sr[i] <= rd_sr[i-1];
			end
		end
	end

	assign rd_return = rd_sr[lat-1];

	// --------------------------------------------------
	// Read credits, one per free FIFO slot
	// --------------------------------------------------
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			credits <= glay_mem_pkg::vs_credit_t'(glay_mem_pkg::vs_fifo_depth);
		end else begin
			case ({rd_accept, rsp_pop})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				// Spend and refund in one cycle cancel out
				default: credits <= credits;
			endcase
		end
	end

endmodule : vertex_req_stage

// File: vertex_resp_fifo.sv
// Response FIFO of the vertex store: buffers returning read words under valid/ready back-pressure

`timescale 1ns/1ps

module vertex_resp_fifo (
	input  logic                   ap_clk,
	input  logic                   rst_n,
	// Returning read data
	input  logic                   rd_return,
	input  glay_mem_pkg::vs_data_t ram_dout,
	// Response stream
	output logic                   rsp_valid,
	input  logic                   rsp_ready,
	output glay_mem_pkg::vs_data_t rsp_data,
	// Credit refund to the request stage
	output logic                   rsp_pop
);

	localparam int depth = glay_mem_pkg::vs_fifo_depth;

	glay_mem_pkg::vs_data_t     buf_mem [depth];
	glay_mem_pkg::vs_fifo_ptr_t wr_ptr;
	glay_mem_pkg::vs_fifo_ptr_t rd_ptr;
	glay_mem_pkg::vs_credit_t   count;

	// Head word goes out whenever something is stored
	assign rsp_valid = (count != '0);
	assign rsp_data  = buf_mem[rd_ptr];
	assign rsp_pop   = rsp_valid & rsp_ready;

	// Next slot index with wrap at depth
	function automatic glay_mem_pkg::vs_fifo_ptr_t ptr_next(
		input glay_mem_pkg::vs_fifo_ptr_t ptr
	);
		if (ptr == glay_mem_pkg::vs_fifo_ptr_t'(depth - 1)) begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	// --------------------------------------------------
	// Storage, written on every returning read
	// --------------------------------------------------
	// Credits guarantee a free slot here
	always_ff @(posedge ap_clk) begin
		if (rd_return) begin
			buf_mem[wr_ptr] <= ram_dout;
		end
	end

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (rd_return) begin
				wr_ptr <= ptr_next(wr_ptr);
			end
			if (rsp_pop) begin
				rd_ptr <= ptr_next(rd_ptr);
			end
		end
	end

	always_ff @(posedge ap_clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else begin
			case ({rd_return, rsp_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				// Push and pop together keep the level
				default: count <= count;
			endcase
		end
	end

endmodule : vertex_resp_fifo

// File: vertex_store_top.sv
// Top level of the vertex property store: request stage, split RAM and response FIFO in a row

`timescale 1ns/1ps

module vertex_store_top (
	input  logic                   ap_clk,
	input  logic                   rst_n,
	// Request stream
	input  logic                   req_valid,
	output logic                   req_ready,
	input  logic                   req_write,
	input  glay_mem_pkg::vs_strb_t req_strb,
	input  glay_mem_pkg::vs_addr_t req_addr,
	input  glay_mem_pkg::vs_data_t req_data,
	// Response stream
	output logic                   rsp_valid,
	input  logic                   rsp_ready,
	output glay_mem_pkg::vs_data_t rsp_data
);

	// --------------------------------------------------
	// Internal RAM port and read tracking
	// --------------------------------------------------
	logic                   ram_en;
	glay_mem_pkg::vs_strb_t ram_we;
	glay_mem_pkg::vs_addr_t ram_addr;
	glay_mem_pkg::vs_data_t ram_din;
	glay_mem_pkg::vs_data_t ram_dout;
	logic                   rd_return;
	logic                   rsp_pop;

	// Request acceptance and credits
	vertex_req_stage inst_req_stage (
		.ap_clk   (ap_clk   ),
		.rst_n    (rst_n    ),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_write(req_write),
		.req_strb (req_strb ),
		.req_addr (req_addr ),
		.req_data (req_data ),
		.ram_en   (ram_en   ),
		.ram_we   (ram_we   ),
		.ram_addr (ram_addr ),
		.ram_din  (ram_din  ),
		.rd_return(rd_return),
		.rsp_pop  (rsp_pop  )
	);

	// Full address space, splits down to four leaves
	vertex_ram_split #(
		.ADDR_W(glay_mem_pkg::vs_addr_w)
	) inst_ram_split (
		.ap_clk  (ap_clk  ),
		.rst_n   (rst_n   ),
		.ram_en  (ram_en  ),
		.ram_we  (ram_we  ),
		.ram_addr(ram_addr),
		.ram_din (ram_din ),
		.ram_dout(ram_dout)
	);

	// In-order read data out
	vertex_resp_fifo inst_resp_fifo (
		.ap_clk   (ap_clk   ),
		.rst_n    (rst_n    ),
		.rd_return(rd_return),
		.ram_dout (ram_dout ),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data (rsp_data ),
		.rsp_pop  (rsp_pop  )
	);

endmodule : vertex_store_top

// File: tb_vertex_store.sv
// Self-checking vertex store testbench that replays the vectors file from the project root

`timescale 1ns/1ps

module tb_vertex_store;

	localparam int          clk_period   = 100;
	localparam int          reset_cycles = 5;
	localparam int unsigned seed         = 32'hf244_9e5c;
	// One request gap in gap_mod cycles on average
	localparam int          gap_mod      = 4;
	// One rsp_ready stall in stall_mod cycles on average
	localparam int          stall_mod    = 4;
	// Cycles allowed for pending reads to come out after the last request
	localparam int          drain_limit  = 100;
	localparam int          depth        = glay_mem_pkg::vs_fifo_depth;
	localparam int          bw           = glay_mem_pkg::vs_byte_w;

	logic                   ap_clk;
	logic                   rst_n;
	logic                   req_valid;
	logic                   req_ready;
	logic                   req_write;
	glay_mem_pkg::vs_strb_t req_strb;
	glay_mem_pkg::vs_addr_t req_addr;
	glay_mem_pkg::vs_data_t req_data;
	logic                   rsp_valid;
	logic                   rsp_ready;
	glay_mem_pkg::vs_data_t rsp_data;

	// Parsed vector table
	logic [7:0]             vec_op [$];
	glay_mem_pkg::vs_addr_t vec_addr [$];
	glay_mem_pkg::vs_strb_t vec_strb [$];
	glay_mem_pkg::vs_data_t vec_data [$];
	int                     n_vec;
	logic                   vec_loaded;

	// Reference memory and expected read words in order
	glay_mem_pkg::vs_data_t ref_mem [2**glay_mem_pkg::vs_addr_w];
	glay_mem_pkg::vs_data_t exp_q [$];

	int                     mismatch_cnt;
	int                     other_cnt;
	int                     stall_left;
	logic                   full_seen;

	vertex_store_top i_dut (
		.ap_clk   (ap_clk   ),
		.rst_n    (rst_n    ),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_write(req_write),
		.req_strb (req_strb ),
		.req_addr (req_addr ),
		.req_data (req_data ),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.rsp_data (rsp_data )
	);

	initial begin
		ap_clk = 1'b0;
		forever #(clk_period / 2) ap_clk = ~ap_clk;
	end

	// --------------------------------------------------
	// Helpers
	// --------------------------------------------------
	// Old word with the strobed bytes taken from the new word
	function automatic glay_mem_pkg::vs_data_t merge_bytes(
		input glay_mem_pkg::vs_data_t old_word,
		input glay_mem_pkg::vs_data_t new_word,
		input glay_mem_pkg::vs_strb_t strb
	);
		glay_mem_pkg::vs_data_t word;
		word = old_word;
		for (int b = 0; b < glay_mem_pkg::vs_strb_w; b++) begin
			if (strb[b]) begin
				word[b*bw +: bw] = new_word[b*bw +: bw];
			end
		end
		return word;
	endfunction

	task automatic load_vectors();
		int          fd;
		int          n;
		string       line;
		logic [7:0]  op;
		logic [31:0] a;
		logic [31:0] s;
		logic [31:0] d;
		fd = $fopen("vertex_store_vectors.txt", "r");
		if (fd == 0) begin
			$display("Cannot open vertex_store_vectors.txt");
			other_cnt++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Blank and comment lines
			if (line.len() < 2 || line.getc(0) == "#" || line.getc(0) == 8'h0a) begin
				continue;
			end
			op = line.getc(0);
			n  = $sscanf(line.substr(2, line.len() - 1), "%h %h %h", a, s, d);
			if (n != 3 || (op != "W" && op != "R" && op != "H")) begin
				$display("Vector line cannot be parsed: %s", line);
				other_cnt++;
			end else begin
				vec_op.push_back(op);
				vec_addr.push_back(a[glay_mem_pkg::vs_addr_w-1:0]);
				vec_strb.push_back(s[glay_mem_pkg::vs_strb_w-1:0]);
				vec_data.push_back(d);
			end
		end
		$fclose(fd);
	endtask

	// Forced stall from an H vector takes priority over random stalls
	task automatic drive_rsp_ready();
		if (stall_left > 0) begin
			rsp_ready = 1'b0;
			stall_left--;
		end else begin
			rsp_ready = ($urandom % stall_mod) != 0;
		end
	endtask

	// --------------------------------------------------
	// Request driver on the falling edge
	// --------------------------------------------------
	task automatic run_requests();
		int   idx;
		logic taken;
		idx   = 0;
		taken = 1'b0;
		while (idx < n_vec || req_valid) begin
			@(negedge ap_clk);
			drive_rsp_ready();
			// Fields stay put until the handshake
			if (!req_valid || taken) begin
				req_valid = 1'b0;
				if (idx < n_vec && ($urandom % gap_mod) != 0) begin
					if (vec_op[idx] == "H") begin
						// Data column is the hold length
						stall_left = int'(vec_data[idx]);
					end else begin
						req_valid = 1'b1;
						req_write = (vec_op[idx] == "W");
						req_addr  = vec_addr[idx];
						req_strb  = vec_strb[idx];
						req_data  = vec_data[idx];
					end
					idx++;
				end
			end
			@(posedge ap_clk);
			taken = req_valid && req_ready;
		end
	endtask

	// Drain pending reads within a cycle budget and then watch for strays
	task automatic drain_responses();
		int waited;
		waited = 0;
		while ((exp_q.size() != 0 || stall_left > 0) && waited < drain_limit) begin
			@(negedge ap_clk);
			drive_rsp_ready();
			waited++;
		end
		@(negedge ap_clk);
		rsp_ready = 1'b1;
		repeat (8) @(negedge ap_clk);
	endtask

	// --------------------------------------------------
	// Monitor and reference model on the rising edge
	// --------------------------------------------------
	always @(posedge ap_clk) begin : monitor
		glay_mem_pkg::vs_data_t exp_word;
		if (rst_n) begin
			// Credits left equal depth minus reads not yet popped
			if (req_ready !== (exp_q.size() < depth)) begin
				$display("Mismatch at %0t: req_ready %b with %0d reads pending",
					$time, req_ready, exp_q.size());
				mismatch_cnt++;
			end
			if (req_ready === 1'b0) begin
				full_seen = 1'b1;
			end
			// Older reads leave before new ones join
			if (rsp_valid && rsp_ready) begin
				if (exp_q.size() == 0) begin
					$display("Response at %0t with no read pending", $time);
					other_cnt++;
				end else begin
					exp_word = exp_q.pop_front();
					if (rsp_data !== exp_word) begin
						$display("Mismatch at %0t: read data %h, expected %h",
							$time, rsp_data, exp_word);
						mismatch_cnt++;
					end
				end
			end
			if (req_valid && req_ready) begin
				if (req_write) begin
					ref_mem[req_addr] = merge_bytes(ref_mem[req_addr], req_data, req_strb);
				end else begin
					exp_q.push_back(ref_mem[req_addr]);
				end
			end
		end
	end

	// Run limit scales with the vector count
	initial begin : watchdog
		wait (vec_loaded);
		#((n_vec + 50) * 20 * clk_period);
		$display("Watchdog timeout at %0t, the run did not finish", $time);
		$display("TEST FAIL");
		$finish;
	end

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		void'($urandom(seed));
		rst_n        = 1'b0;
		req_valid    = 1'b0;
		req_write    = 1'b0;
		req_strb     = '0;
		req_addr     = '0;
		req_data     = '0;
		rsp_ready    = 1'b0;
		mismatch_cnt = 0;
		other_cnt    = 0;
		stall_left   = 0;
		full_seen    = 1'b0;
		vec_loaded   = 1'b0;
		load_vectors();
		n_vec      = vec_op.size();
		vec_loaded = 1'b1;
		if (n_vec == 0) begin
			$display("No request vectors were loaded");
			other_cnt++;
		end
		repeat (reset_cycles) @(posedge ap_clk);
		@(negedge ap_clk);
		rst_n = 1'b1;
		// Idle state straight out of reset
		if (req_ready !== 1'b1) begin
			$display("Mismatch at %0t: req_ready %b after reset, expected 1", $time, req_ready);
			mismatch_cnt++;
		end
		if (rsp_valid !== 1'b0) begin
			$display("Mismatch at %0t: rsp_valid %b after reset, expected 0", $time, rsp_valid);
			mismatch_cnt++;
		end
		run_requests();
		drain_responses();
		if (exp_q.size() != 0) begin
			$display("%0d reads never returned a response", exp_q.size());
			other_cnt++;
		end
		if (!full_seen) begin
			$display("req_ready never dropped, the credit limit was not reached");
			other_cnt++;
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, other_cnt);
		if (mismatch_cnt == 0 && other_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule : tb_vertex_store

// File: vertex_store_vectors.txt
# Columns: op addr strb data, all hex. W writes, R reads (strb and data ignored)
# H holds rsp_ready low for data cycles, its addr and strb are ignored
W 005 f 11111111
W 405 f 22222222
W 805 f 33333333
W c05 f 44444444
W 3ff f a5a5a5a5
W 400 f 0f0f0f0f
W bff f f0f0f0f0
W fff f 5a5a5a5a
R 005 0 00000000
R 405 0 00000000
R 805 0 00000000
R c05 0 00000000
R 3ff 0 00000000
R 400 0 00000000
R bff 0 00000000
R fff 0 00000000
W 405 1 000000ee
W 805 6 00abcd00
W c05 8 99000000
W 005 c 7f7e0000
R 405 0 00000000
R 805 0 00000000
R c05 0 00000000
R 005 0 00000000
W 123 f 0badf00d
W 923 f c001d00d
R 123 0 00000000
R 923 0 00000000
R 123 0 00000000
R 923 0 00000000
W 6ab f 600dcafe
R 6ab 0 00000000
W 6ab 3 0000beef
R 6ab 0 00000000
H 000 0 00000010
R 005 0 00000000
R 405 0 00000000
R 805 0 00000000
R c05 0 00000000
R 123 0 00000000
R 923 0 00000000
R fff 0 00000000

// File: src.f
glay_mem_pkg.sv
vertex_ram_leaf.sv
vertex_ram_split.sv
vertex_req_stage.sv
vertex_resp_fifo.sv
vertex_store_top.sv
tb_vertex_store.sv

// File: run_sim.sh
#!/bin/sh
# Builds the vertex store testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f src.f --top-module tb_vertex_store -o sim_vertex_store
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_vertex_store)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
else
	echo "Pass message not found in simulation output"
	exit 1
fi
